// ==== Bender.yml ====
package:
  name: eth_mac_flow_ctrl

export_include_dirs:
  - include

sources:
  - files:
      - src/eth_mac_pkg.sv
      - src/mac_pause_ctrl_tx.sv
      - src/mac_ctrl_tx.sv
      - src/mac_ctrl_rx.sv
      - src/mac_pause_ctrl_rx.sv
      - src/eth_mac_flow_ctrl.sv
  - target: simulation
    files:
      - tb/tb_eth_mac_flow_ctrl.sv

// ==== flist.f ====
+incdir+include
src/eth_mac_pkg.sv
src/mac_pause_ctrl_tx.sv
src/mac_ctrl_tx.sv
src/mac_ctrl_rx.sv
src/mac_pause_ctrl_rx.sv
src/eth_mac_flow_ctrl.sv
tb/tb_eth_mac_flow_ctrl.sv

// ==== include/eth_mac_config.svh ====
// Flow control configuration
`ifndef ETH_MAC_CONFIG_SVH
`define ETH_MAC_CONFIG_SVH

// Stream beat geometry.
`define ETH_DATA_W 64
`define ETH_KEEP_W 8

// One quantum is 512 bit times.
`define QUANTA_CYCLES (512 / `ETH_DATA_W)

// Control frame is 60 bytes before the FCS, so the last beat keeps four bytes.
`define MCF_BEATS 8
`define MCF_LAST_KEEP 8'h0F

// Reserved multicast address for PAUSE.
`define DEF_PAUSE_DST 48'h01_80_C2_00_00_01

// MAC control ethertype.
`define DEF_MCF_TYPE 16'h8808

`endif

// ==== src/eth_mac_flow_ctrl.sv ====
// Ethernet MAC flow control
`timescale 1ns/1ps
`default_nettype none

module eth_mac_flow_ctrl
    import eth_mac_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire tx_lfc_cfg_t tx_cfg,
    input  wire rx_mcf_cfg_t rx_cfg,
    input  wire axis_beat_t  tx_in,
    input  wire logic        tx_in_valid,
    output logic             tx_in_ready,
    output axis_beat_t       tx_out,
    output logic             tx_out_valid,
    input  wire logic        tx_out_ready,
    input  wire axis_beat_t  rx_in,
    input  wire logic        rx_in_valid,
    output axis_beat_t       rx_out,
    output logic             rx_out_valid,
    input  wire logic        tx_lfc_req,
    input  wire logic        tx_lfc_resend,
    input  wire logic        tx_pause_req,
    input  wire logic        tx_lfc_pause_en,
    input  wire logic        rx_lfc_en,
    input  wire logic        rx_lfc_ack,
    output logic             tx_pause_ack,
    output logic             rx_lfc_req
);

mcf_t mcf_tx;
logic mcf_tx_valid;
logic mcf_tx_ready;
mcf_t mcf_rx;
logic mcf_rx_valid;
logic tx_pause_req_int;
logic rx_lfc_ack_int;

// Received PAUSE can halt our own transmitter directly.
assign tx_pause_req_int = tx_pause_req || (tx_lfc_pause_en && rx_lfc_req);
assign rx_lfc_ack_int = rx_lfc_ack || (tx_lfc_pause_en && tx_pause_ack);

mac_pause_ctrl_tx mac_pause_ctrl_tx_inst (
    .clk(clk),
    .reset(reset),
    .cfg(tx_cfg),
    .tx_lfc_req(tx_lfc_req),
    .tx_lfc_resend(tx_lfc_resend),
    .mcf_tx(mcf_tx),
    .mcf_tx_valid(mcf_tx_valid),
    .mcf_tx_ready(mcf_tx_ready)
);

mac_ctrl_tx mac_ctrl_tx_inst (
    .clk(clk),
    .reset(reset),
    .tx_in(tx_in),
    .tx_in_valid(tx_in_valid),
    .tx_in_ready(tx_in_ready),
    .tx_out(tx_out),
    .tx_out_valid(tx_out_valid),
    .tx_out_ready(tx_out_ready),
    .mcf_tx(mcf_tx),
    .mcf_tx_valid(mcf_tx_valid),
    .mcf_tx_ready(mcf_tx_ready),
    .tx_pause_req(tx_pause_req_int),
    .tx_pause_ack(tx_pause_ack)
);

mac_ctrl_rx mac_ctrl_rx_inst (
    .clk(clk),
    .reset(reset),
    .cfg(rx_cfg),
    .rx_in(rx_in),
    .rx_in_valid(rx_in_valid),
    .rx_out(rx_out),
    .rx_out_valid(rx_out_valid),
    .mcf_rx(mcf_rx),
    .mcf_rx_valid(mcf_rx_valid)
);

mac_pause_ctrl_rx mac_pause_ctrl_rx_inst (
    .clk(clk),
    .reset(reset),
    .mcf_rx(mcf_rx),
    .mcf_rx_valid(mcf_rx_valid),
    .rx_lfc_en(rx_lfc_en),
    .rx_lfc_req(rx_lfc_req),
    .rx_lfc_ack(rx_lfc_ack_int)
);

endmodule

`default_nettype wire

// ==== src/eth_mac_pkg.sv ====
// Flow control types
`default_nettype none

`include "eth_mac_config.svh"

package eth_mac_pkg;

typedef struct packed {
    logic [`ETH_DATA_W-1:0] data;
    logic [`ETH_KEEP_W-1:0] keep;
    logic                   last;
    logic                   user;  // Bad frame.
} axis_beat_t;

typedef enum logic [15:0] {
    OPC_PAUSE = 16'h0001
} mcf_opcode_e;

// Field order matches the order on the wire.
typedef struct packed {
    logic [47:0] eth_dst;
    logic [47:0] eth_src;
    logic [15:0] eth_type;
    logic [15:0] opcode;
    logic [15:0] quanta;
} mcf_t;

typedef struct packed {
    logic [47:0] eth_dst;
    logic [47:0] eth_src;
    logic [15:0] eth_type;
    logic [15:0] opcode;
    logic [15:0] quanta;
    logic [15:0] refresh;  // In quanta.
    logic        en;
} tx_lfc_cfg_t;

typedef struct packed {
    logic [47:0] eth_dst_mcast;
    logic [15:0] eth_type;
    logic [15:0] opcode_lfc;
    logic        enable;
} rx_mcf_cfg_t;

typedef enum logic [1:0] {ST_IDLE, ST_DATA, ST_MCF} ctrl_tx_state_e;

typedef enum logic [1:0] {ST_OFF, ST_XOFF_PEND, ST_ON, ST_XON_PEND} pause_tx_state_e;

endpackage

`default_nettype wire

// ==== src/mac_ctrl_rx.sv ====
// Receive control frame detection
`timescale 1ns/1ps
`default_nettype none

`include "eth_mac_config.svh"

module mac_ctrl_rx
    import eth_mac_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire rx_mcf_cfg_t cfg,
    input  wire axis_beat_t  rx_in,
    input  wire logic        rx_in_valid,
    output axis_beat_t       rx_out,
    output logic             rx_out_valid,
    output mcf_t             mcf_rx,
    output logic             mcf_rx_valid
);

logic [1:0]             beat_idx;
logic [`ETH_DATA_W-1:0] in_be;
logic                   match;
logic                   mark;

// Beat in network order, frame byte 0 on top.
assign in_be = {<<8{rx_in.data}};

// Header fields are complete once beat 2 is reached.
assign match = cfg.enable && beat_idx[1] &&
    mcf_rx.eth_dst == cfg.eth_dst_mcast &&
    mcf_rx.eth_type == cfg.eth_type &&
    mcf_rx.opcode == cfg.opcode_lfc;
assign mark = rx_in_valid && rx_in.last && match;

always_ff @(posedge clk) begin
    if (reset) begin
        beat_idx <= '0;
        rx_out_valid <= 1'b0;
        mcf_rx_valid <= 1'b0;
    end else begin
        rx_out_valid <= rx_in_valid;
        mcf_rx_valid <= mark;
        if (rx_in_valid) begin
            if (rx_in.last) beat_idx <= '0;
            else if (beat_idx != 2'd3) beat_idx <= beat_idx + 1'b1;  // Saturates.
        end
    end
end

always_ff @(posedge clk) begin
    rx_out <= rx_in;
    rx_out.user <= rx_in.user || mark;  // Drop downstream.
    if (rx_in_valid) begin
        case (beat_idx)
            2'd0: begin
                mcf_rx.eth_dst <= in_be[63:16];
                mcf_rx.eth_src[47:32] <= in_be[15:0];
            end
            2'd1: begin
                mcf_rx.eth_src[31:0] <= in_be[63:32];
                mcf_rx.eth_type <= in_be[31:16];
                mcf_rx.opcode <= in_be[15:0];
            end
            2'd2: mcf_rx.quanta <= in_be[63:48];
            default: ;
        endcase
    end
end

a_strobe_on_last: assert property (@(posedge clk) disable iff (reset)
    mcf_rx_valid |-> rx_out_valid && rx_out.last && rx_out.user);

endmodule

`default_nettype wire

// ==== src/mac_ctrl_tx.sv ====
// Control frame insertion and transmit pause
`timescale 1ns/1ps
`default_nettype none

`include "eth_mac_config.svh"

module mac_ctrl_tx
    import eth_mac_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire axis_beat_t tx_in,
    input  wire logic       tx_in_valid,
    output logic            tx_in_ready,
    output axis_beat_t      tx_out,
    output logic            tx_out_valid,
    input  wire logic       tx_out_ready,
    input  wire mcf_t       mcf_tx,
    input  wire logic       mcf_tx_valid,
    output logic            mcf_tx_ready,
    input  wire logic       tx_pause_req,
    output logic            tx_pause_ack
);

localparam int BEAT_W = $clog2(`MCF_BEATS);
localparam int FRAME_W = `MCF_BEATS * `ETH_DATA_W;

ctrl_tx_state_e         state;
logic [BEAT_W-1:0]      beat_cnt;
mcf_t                   mcf_q;
logic                   data_pend;
logic                   idle_free;
logic                   data_en;
logic                   data_xfer;
logic                   mcf_last;
logic [FRAME_W-1:0]     frame_be;
logic [`ETH_DATA_W-1:0] beat_be;

// A data beat offered but not yet taken keeps the idle slot.
assign idle_free = (state == ST_IDLE) && !data_pend;
assign data_en = (state == ST_DATA) || ((state == ST_IDLE) &&
    (data_pend || (!mcf_tx_valid && !tx_pause_req && !tx_pause_ack)));
assign data_xfer = data_en && tx_in_valid && tx_out_ready;
assign mcf_tx_ready = idle_free;

// Whole frame in network order, first byte at the top.
assign frame_be = {mcf_q, {(FRAME_W - $bits(mcf_t)){1'b0}}};
assign beat_be = frame_be[FRAME_W - 1 - beat_cnt * `ETH_DATA_W -: `ETH_DATA_W];
assign mcf_last = beat_cnt == BEAT_W'(`MCF_BEATS - 1);

always_comb begin
    tx_out = tx_in;
    tx_out_valid = data_en && tx_in_valid;
    tx_in_ready = data_en && tx_out_ready;
    if (state == ST_MCF) begin
        tx_out.data = {<<8{beat_be}};  // Frame byte 0 goes to the low lane.
        tx_out.keep = mcf_last ? `MCF_LAST_KEEP : '1;
        tx_out.last = mcf_last;
        tx_out.user = 1'b0;
        tx_out_valid = 1'b1;
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        state <= ST_IDLE;
        beat_cnt <= '0;
        data_pend <= 1'b0;
        tx_pause_ack <= 1'b0;
    end else begin
        data_pend <= (state == ST_IDLE) && data_en && tx_in_valid && !tx_out_ready;

        // Pause only takes effect at a frame boundary.
        if (!tx_pause_req) begin
            tx_pause_ack <= 1'b0;
        end else if (idle_free || (data_xfer && tx_in.last)) begin
            tx_pause_ack <= 1'b1;
        end

        case (state)
            ST_IDLE: begin
                if (idle_free && mcf_tx_valid) begin
                    state <= ST_MCF;
                    beat_cnt <= '0;
                end else if (data_xfer && !tx_in.last) begin
                    state <= ST_DATA;
                end
            end
            ST_DATA: if (data_xfer && tx_in.last) state <= ST_IDLE;
            ST_MCF: begin
                if (tx_out_ready) begin
                    beat_cnt <= mcf_last ? '0 : beat_cnt + 1'b1;
                    if (mcf_last) state <= ST_IDLE;
                end
            end
            default: state <= ST_IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (idle_free && mcf_tx_valid) mcf_q <= mcf_tx;
end

// An open user frame is never interrupted by a control frame.
a_no_split: assert property (@(posedge clk) disable iff (reset)
    state != ST_MCF && tx_out_valid && tx_out_ready && !tx_out.last |=> state != ST_MCF);

a_out_hold: assert property (@(posedge clk) disable iff (reset)
    tx_out_valid && !tx_out_ready |=> tx_out_valid && $stable(tx_out));

endmodule

`default_nettype wire

// ==== src/mac_pause_ctrl_rx.sv ====
// Received PAUSE timer
`timescale 1ns/1ps
`default_nettype none

`include "eth_mac_config.svh"

module mac_pause_ctrl_rx
    import eth_mac_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire mcf_t mcf_rx,
    input  wire logic mcf_rx_valid,
    input  wire logic rx_lfc_en,
    output logic      rx_lfc_req,
    input  wire logic rx_lfc_ack
);

localparam int CNT_W = 16 + $clog2(`QUANTA_CYCLES);

logic [CNT_W-1:0] pause_cnt;  // Remaining pause in cycles.
logic             load;

assign load = mcf_rx_valid && rx_lfc_en && (mcf_rx.opcode == OPC_PAUSE);

always_ff @(posedge clk) begin
    if (reset) begin
        pause_cnt <= '0;
        rx_lfc_req <= 1'b0;
    end else if (!rx_lfc_en) begin
        pause_cnt <= '0;
        rx_lfc_req <= 1'b0;
    end else if (load) begin
        // A new frame restarts the time, quanta zero ends the pause.
        pause_cnt <= CNT_W'(mcf_rx.quanta * `QUANTA_CYCLES);
        rx_lfc_req <= mcf_rx.quanta != 16'd0;
    end else begin
        // Time only runs once the pause is honoured.
        if (rx_lfc_ack && pause_cnt != '0) begin
            pause_cnt <= pause_cnt - 1'b1;
        end
        if (pause_cnt == '0) begin
            rx_lfc_req <= 1'b0;
        end
    end
end

// Remaining pause time is always backed by a request.
a_req_while_cnt: assert property (@(posedge clk) disable iff (reset)
    pause_cnt != '0 |-> rx_lfc_req);

endmodule

`default_nettype wire

// ==== src/mac_pause_ctrl_tx.sv ====
// PAUSE frame generator
`timescale 1ns/1ps
`default_nettype none

`include "eth_mac_config.svh"

module mac_pause_ctrl_tx
    import eth_mac_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire tx_lfc_cfg_t cfg,
    input  wire logic        tx_lfc_req,
    input  wire logic        tx_lfc_resend,
    output mcf_t             mcf_tx,
    output logic             mcf_tx_valid,
    input  wire logic        mcf_tx_ready
);

localparam int CNT_W = 16 + $clog2(`QUANTA_CYCLES);

pause_tx_state_e  state;
logic [CNT_W-1:0] refresh_cnt;
logic             send_xoff;
logic             send_xon;

assign mcf_tx_valid = (state == ST_XOFF_PEND) || (state == ST_XON_PEND);

always_comb begin
    send_xoff = 1'b0;
    send_xon = 1'b0;
    if (cfg.en) begin
        case (state)
            ST_OFF: send_xoff = tx_lfc_req;
            ST_ON: begin
                send_xon = !tx_lfc_req;
                send_xoff = tx_lfc_req && (tx_lfc_resend || refresh_cnt == '0);
            end
            default: ;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        state <= ST_OFF;
        refresh_cnt <= '0;
    end else begin
        case (state)
            ST_OFF: if (send_xoff) state <= ST_XOFF_PEND;
            ST_XOFF_PEND: begin
                if (mcf_tx_ready) begin
                    state <= ST_ON;
                    refresh_cnt <= CNT_W'(cfg.refresh * `QUANTA_CYCLES);
                end
            end
            ST_ON: begin
                if (send_xoff) state <= ST_XOFF_PEND;
                else if (send_xon) state <= ST_XON_PEND;
                else if (!cfg.en) state <= ST_OFF;  // Far end times out on its own.
                else if (refresh_cnt != '0) refresh_cnt <= refresh_cnt - 1'b1;
            end
            ST_XON_PEND: if (mcf_tx_ready) state <= ST_OFF;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (send_xoff || send_xon) begin
        mcf_tx.eth_dst <= cfg.eth_dst;
        mcf_tx.eth_src <= cfg.eth_src;
        mcf_tx.eth_type <= cfg.eth_type;
        mcf_tx.opcode <= cfg.opcode;
        mcf_tx.quanta <= send_xoff ? cfg.quanta : 16'd0;  // XON carries zero.
    end
end

// Frame fields held until mac_ctrl_tx takes the frame.
a_mcf_hold: assert property (@(posedge clk) disable iff (reset)
    mcf_tx_valid && !mcf_tx_ready |=> mcf_tx_valid && $stable(mcf_tx));

endmodule

`default_nettype wire

// ==== tb/tb_eth_mac_flow_ctrl.sv ====
// Flow control testbench
`timescale 1ns/1ps
`default_nettype none

`include "eth_mac_config.svh"

module tb_eth_mac_flow_ctrl
    import eth_mac_pkg::*;
();

localparam int NROWS = 10;
localparam logic [47:0] SRC_ADDR = 48'h02_00_00_AB_CD_EF;
localparam logic [47:0] BAD_DST = 48'h01_80_C2_00_00_02;

typedef enum logic [2:0] {K_DATA, K_LFC, K_LFC_MID, K_RX, K_PAUSE, K_LOOP} kind_e;

typedef struct packed {
    kind_e       kind;
    logic [7:0]  len;     // User frame beats.
    logic [15:0] quanta;
    logic [47:0] dst;
    logic [15:0] etype;
    logic        bp;      // Random tx_out_ready gaps.
    logic        hit;     // Frame or request expected.
} scenario_t;

logic        clk;
logic        reset;
tx_lfc_cfg_t tx_cfg;
rx_mcf_cfg_t rx_cfg;
axis_beat_t  tx_in;
logic        tx_in_valid;
logic        tx_in_ready;
axis_beat_t  tx_out;
logic        tx_out_valid;
logic        tx_out_ready = 1'b1;
axis_beat_t  rx_in;
logic        rx_in_valid;
axis_beat_t  rx_out;
logic        rx_out_valid;
logic        tx_lfc_req;
logic        tx_lfc_resend;
logic        tx_pause_req;
logic        tx_lfc_pause_en;
logic        rx_lfc_en;
logic        rx_lfc_ack;
logic        tx_pause_ack;
logic        rx_lfc_req;

scenario_t  rows [NROWS];
axis_beat_t mcf_buf [`MCF_BEATS];
axis_beat_t tx_exp [$];
axis_beat_t tx_got [$];
axis_beat_t rx_exp [$];
axis_beat_t rx_got [$];
logic       bp_on = 1'b0;
logic       rx_in_valid_d = 1'b0;
int         checks = 0;
int         errors = 0;

eth_mac_flow_ctrl i_dut (.*);

initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
end

always @(posedge clk) begin
    tx_out_ready <= !bp_on || (($urandom % 4) != 0);
end

// Outputs are settled at the falling edge, a transfer follows at the next rising edge.
always @(negedge clk) begin
    if (!reset) begin
        compare_value("rx_out_valid", rx_out_valid, rx_in_valid_d);
        if (tx_out_valid && tx_out_ready) tx_got.push_back(tx_out);
        if (rx_out_valid) rx_got.push_back(rx_out);
    end
    rx_in_valid_d = rx_in_valid;
end

task automatic compare_value(input string name, input logic [127:0] got,
        input logic [127:0] exp);
    checks++;
    assert (got === exp) else begin
        errors++;
        $display("ERR %0t %s got %0h exp %0h", $time, name, got, exp);
    end
endtask

task automatic expect_true(input logic ok, input string what);
    checks++;
    assert (ok === 1'b1) else begin
        errors++;
        $display("Failure at %0t: %s", $time, what);
    end
endtask

// Lays out a PAUSE frame by the byte order rule, bytes past the quanta are zero.
task automatic build_mcf(input logic [47:0] dst, input logic [15:0] etype,
        input logic [15:0] quanta);
    logic [7:0]  bytes [`MCF_BEATS * 8];
    logic [15:0] opc;
    opc = OPC_PAUSE;
    foreach (bytes[n]) bytes[n] = 8'h00;
    for (int n = 0; n < 6; n++) begin
        bytes[n] = dst[47 - 8 * n -: 8];
        bytes[6 + n] = SRC_ADDR[47 - 8 * n -: 8];
    end
    bytes[12] = etype[15:8];
    bytes[13] = etype[7:0];
    bytes[14] = opc[15:8];
    bytes[15] = opc[7:0];
    bytes[16] = quanta[15:8];
    bytes[17] = quanta[7:0];
    for (int beat = 0; beat < `MCF_BEATS; beat++) begin
        for (int k = 0; k < 8; k++) begin
            mcf_buf[beat].data[8 * k +: 8] = bytes[8 * beat + k];
        end
        mcf_buf[beat].last = (beat == `MCF_BEATS - 1);
        mcf_buf[beat].keep = mcf_buf[beat].last ? `MCF_LAST_KEEP : 8'hFF;
        mcf_buf[beat].user = 1'b0;
    end
endtask

task automatic push_mcf_tx(input logic [15:0] quanta);
    build_mcf(`DEF_PAUSE_DST, `DEF_MCF_TYPE, quanta);
    foreach (mcf_buf[i]) tx_exp.push_back(mcf_buf[i]);
endtask

task automatic send_tx_frame(input int len);
    axis_beat_t b;
    for (int i = 0; i < len; i++) begin
        b.data = {$urandom, $urandom};
        b.last = (i == len - 1);
        b.keep = b.last ? 8'h3F : 8'hFF;
        b.user = 1'b0;
        tx_exp.push_back(b);
        @(posedge clk);
        tx_in <= b;
        tx_in_valid <= 1'b1;
        do @(negedge clk); while (!tx_in_ready);
    end
    @(posedge clk);
    tx_in_valid <= 1'b0;
endtask

task automatic send_rx_frame(input scenario_t row);
    axis_beat_t b;
    build_mcf(row.dst, row.etype, row.quanta);
    foreach (mcf_buf[i]) begin
        b = mcf_buf[i];
        @(posedge clk);
        rx_in <= b;
        rx_in_valid <= 1'b1;
        b.user = b.last && row.hit;  // Recognised PAUSE is marked bad.
        rx_exp.push_back(b);
    end
    @(posedge clk);
    rx_in_valid <= 1'b0;
endtask

task automatic drain_and_compare(input bit rx_side);
    axis_beat_t got_q [$];
    axis_beat_t exp_q [$];
    string      name;
    name = rx_side ? "rx_out" : "tx_out";
    do begin
        @(negedge clk);
    end while (rx_side ? rx_got.size() < rx_exp.size() : tx_got.size() < tx_exp.size());
    repeat (12) @(negedge clk);  // Room for stray beats.
    if (rx_side) begin
        got_q = rx_got;
        exp_q = rx_exp;
        rx_got.delete();
        rx_exp.delete();
    end else begin
        got_q = tx_got;
        exp_q = tx_exp;
        tx_got.delete();
        tx_exp.delete();
    end
    compare_value({name, " beat count"}, got_q.size(), exp_q.size());
    foreach (exp_q[i]) begin
        if (i < got_q.size()) compare_value($sformatf("%s[%0d]", name, i), got_q[i], exp_q[i]);
    end
endtask

task automatic run_row(input scenario_t row);
    int high;
    @(posedge clk);
    bp_on <= row.bp;
    case (row.kind)
        K_DATA: begin
            send_tx_frame(row.len);
            drain_and_compare(1'b0);
        end
        K_LFC: begin
            tx_cfg.quanta <= row.quanta;
            tx_cfg.en <= row.hit;
            tx_lfc_req <= 1'b1;
            if (row.hit) push_mcf_tx(row.quanta);
            drain_and_compare(1'b0);
            @(posedge clk);
            tx_lfc_req <= 1'b0;
            if (row.hit) push_mcf_tx(16'd0);  // XON.
            drain_and_compare(1'b0);
        end
        K_LFC_MID: begin
            tx_cfg.quanta <= row.quanta;
            tx_cfg.en <= 1'b1;
            fork
                send_tx_frame(row.len);
                begin
                    do @(negedge clk); while (tx_got.size() == 0);
                    @(posedge clk);
                    tx_lfc_req <= 1'b1;
                end
            join
            push_mcf_tx(row.quanta);
            drain_and_compare(1'b0);
            @(posedge clk);
            tx_lfc_req <= 1'b0;
            push_mcf_tx(16'd0);
            drain_and_compare(1'b0);
        end
        K_RX: begin
            send_rx_frame(row);
            if (row.hit) begin
                do @(negedge clk); while (!rx_lfc_req);
                high = 0;
                while (rx_lfc_req) begin
                    high++;
                    @(negedge clk);
                end
                // Counter loads quanta x 8, request drops the cycle after zero.
                compare_value("rx_lfc_req high cycles", high,
                    row.quanta * `QUANTA_CYCLES + 1);
            end else begin
                repeat (20) begin
                    @(negedge clk);
                    expect_true(!rx_lfc_req, "rx_lfc_req rose for a frame that does not match");
                end
            end
            drain_and_compare(1'b1);
        end
        K_PAUSE: begin
            tx_pause_req <= 1'b1;
            do @(negedge clk); while (!tx_pause_ack);
            fork
                send_tx_frame(row.len);
                begin
                    repeat (30) @(negedge clk);
                    expect_true(tx_got.size() == 0, "a data beat left while tx_pause_ack was high");
                    @(posedge clk);
                    tx_pause_req <= 1'b0;
                end
            join
            drain_and_compare(1'b0);
        end
        K_LOOP: begin
            tx_lfc_pause_en <= 1'b1;
            rx_lfc_ack <= 1'b0;
            send_rx_frame(row);
            do @(negedge clk); while (!rx_lfc_req);
            fork
                send_tx_frame(row.len);
                begin
                    do @(negedge clk); while (rx_lfc_req);
                    expect_true(tx_got.size() == 0, "a data beat left during the received pause");
                end
            join
            drain_and_compare(1'b0);
            drain_and_compare(1'b1);
            @(posedge clk);
            tx_lfc_pause_en <= 1'b0;
            rx_lfc_ack <= 1'b1;
        end
        default: expect_true(1'b0, "unknown scenario kind in the table");
    endcase
    repeat (4) @(posedge clk);
endtask

// Budget per row covers the longest frame, the longest pause and some slack.
function automatic int watchdog_cycles();
    int longest;
    int maxq;
    longest = `MCF_BEATS;
    maxq = 0;
    foreach (rows[r]) begin
        if (rows[r].len > longest) longest = rows[r].len;
        if (rows[r].quanta > maxq) maxq = rows[r].quanta;
    end
    return NROWS * (4 * longest + maxq * `QUANTA_CYCLES + 300);
endfunction

task automatic watchdog(input int cycles);
    repeat (cycles) @(posedge clk);
    $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
    $display("Checks %0d, errors %0d", checks, errors + 1);
    $display("=== FAIL ===");
    $finish;
endtask

initial begin
    int limit;
    void'($urandom(51));
    reset = 1'b1;
    tx_cfg = '{`DEF_PAUSE_DST, SRC_ADDR, `DEF_MCF_TYPE, OPC_PAUSE, 16'h0040, 16'd200, 1'b1};
    rx_cfg = '{`DEF_PAUSE_DST, `DEF_MCF_TYPE, OPC_PAUSE, 1'b1};
    tx_in = '0;
    tx_in_valid = 1'b0;
    rx_in = '0;
    rx_in_valid = 1'b0;
    tx_lfc_req = 1'b0;
    tx_lfc_resend = 1'b0;
    tx_pause_req = 1'b0;
    tx_lfc_pause_en = 1'b0;
    rx_lfc_en = 1'b1;
    rx_lfc_ack = 1'b1;

    rows[0] = '{K_DATA, 8'd5, 16'd0, `DEF_PAUSE_DST, `DEF_MCF_TYPE, 1'b0, 1'b1};
    rows[1] = '{K_DATA, 8'd9, 16'd0, `DEF_PAUSE_DST, `DEF_MCF_TYPE, 1'b1, 1'b1};
    rows[2] = '{K_LFC, 8'd0, 16'h0040, `DEF_PAUSE_DST, `DEF_MCF_TYPE, 1'b1, 1'b1};
    rows[3] = '{K_LFC, 8'd0, 16'h0040, `DEF_PAUSE_DST, `DEF_MCF_TYPE, 1'b0, 1'b0};
    rows[4] = '{K_LFC_MID, 8'd6, 16'h0020, `DEF_PAUSE_DST, `DEF_MCF_TYPE, 1'b1, 1'b1};
    rows[5] = '{K_RX, 8'd0, 16'd3, `DEF_PAUSE_DST, `DEF_MCF_TYPE, 1'b0, 1'b1};
    rows[6] = '{K_RX, 8'd0, 16'd3, `DEF_PAUSE_DST, 16'h8809, 1'b0, 1'b0};
    rows[7] = '{K_RX, 8'd0, 16'd3, BAD_DST, `DEF_MCF_TYPE, 1'b0, 1'b0};
    rows[8] = '{K_PAUSE, 8'd4, 16'd0, `DEF_PAUSE_DST, `DEF_MCF_TYPE, 1'b0, 1'b1};
    rows[9] = '{K_LOOP, 8'd3, 16'd4, `DEF_PAUSE_DST, `DEF_MCF_TYPE, 1'b0, 1'b1};

    limit = watchdog_cycles();
    fork
        watchdog(limit);
    join_none

    repeat (8) @(posedge clk);
    reset <= 1'b0;
    foreach (rows[r]) run_row(rows[r]);

    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
        $display("=== PASS ===");
    end else begin
        $display("=== FAIL ===");
    end
    $finish;
end

endmodule

`default_nettype wire
